// File: Makefile
# Verilator build and run for the AHB-Lite memory subsystem

VERILATOR := verilator
TOP       := ahb_mem_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
RUN_FLAGS := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation binary is the test result
run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
hdl/ahb_mem_pkg.sv
hdl/ahb_rst_ctrl.sv
hdl/ahb_decoder.sv
hdl/ahb_mem_slave.sv
hdl/ahb_mem_top.sv
bench/ahb_mem_checker.sv
bench/ahb_mem_tb.sv

// File: bench/ahb_mem_checker.sv
/*
  Protocol assertions for the AHB-Lite response path.
  Bound into the address decoder. Every failure raises $error and bumps
  a counter that the testbench watches.
*/
module ahb_mem_checker
  import ahb_mem_pkg::*;
(
  input logic    clk_ahb,
  input logic    rst_ahb_n_i,
  input addr_t   haddr_i,
  input htrans_t htrans_i,
  input logic    hready_i,
  input logic    hresp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int   fail_cnt = 0;
  logic addr_pending;

  // Transfer waiting on the address bus during a stall
  assign addr_pending = !hready_i && ((htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ));

  //////////////////////////////////////////////////
  // ERROR response shape
  //////////////////////////////////////////////////

  // First ERROR cycle stalls the bus
  err_first_stall: assert property (
    @(posedge clk_ahb) disable iff (!rst_ahb_n_i)
    $rose(hresp_i) |-> !hready_i
  ) else begin
    fail_cnt++;
    $error("hresp high with hready high on first ERROR cycle");
  end

  // Second ERROR cycle completes it
  err_second_ready: assert property (
    @(posedge clk_ahb) disable iff (!rst_ahb_n_i)
    (hresp_i && !hready_i) |=> (hresp_i && hready_i)
  ) else begin
    fail_cnt++;
    $error("ERROR response not completed in its second cycle");
  end

  //////////////////////////////////////////////////
  // Master side and ready
  //////////////////////////////////////////////////
  addr_held: assert property (
    @(posedge clk_ahb) disable iff (!rst_ahb_n_i)
    addr_pending |=> ($stable(haddr_i) && $stable(htrans_i))
  ) else begin
    fail_cnt++;
    $error("Address phase changed while hready was low");
  end

  ready_known: assert property (
    @(posedge clk_ahb) disable iff (!rst_ahb_n_i)
    !$isunknown(hready_i)
  ) else begin
    fail_cnt++;
    $error("Unknown value on hready");
  end

endmodule

bind ahb_decoder ahb_mem_checker checker_i (
  .clk_ahb    (clk_ahb),
  .rst_ahb_n_i(rst_ahb_n_i),
  .haddr_i    (haddr_i),
  .htrans_i   (htrans_i),
  .hready_i   (hready_o),
  .hresp_i    (hresp_o)
);

// File: bench/ahb_mem_tb.sv
/*
  Directed testbench for the AHB-Lite memory subsystem.
  Issues single transfers to both regions and to unmapped space, checks
  read data, wait states and ERROR responses against a byte model, and
  pulses the soft reset request. Built and run through the Makefile.
*/
module ahb_mem_tb
  import ahb_mem_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 40;
  localparam int DRV_DLY      = 2;
  localparam int RESET_CYCLES = 8;
  localparam int N_WORDS      = 12;
  localparam int N_LANES      = 6;
  localparam int MEM_BYTES    = 2 ** MEM_AW;
  localparam int READY_LIMIT  = 20;
  localparam logic [31:0] SEED = 32'hc939ed9a;
  // Transfers over all tests, for the watchdog
  localparam int N_XFERS  = 4 * N_WORDS + 4 * N_LANES + 14;
  localparam int WD_CYCLES = N_XFERS * 10 + RESET_CYCLES + 2 * (RST_HOLD + 2) + 10;

  logic    clk_ahb;
  logic    sysrst_n;
  logic    rst_req_i;
  addr_t   haddr_i;
  htrans_t htrans_i;
  logic    hwrite_i;
  hsize_t  hsize_i;
  data_t   hwdata_i;
  data_t   hrdata_o;
  logic    hready_o;
  logic    hresp_o;

  // External region bytes first, SDRAM bytes after
  logic [7:0] model_mem [2 * MEM_BYTES];

  ahb_mem_top dut_i (
    .clk_ahb  (clk_ahb),
    .sysrst_n (sysrst_n),
    .rst_req_i(rst_req_i),
    .haddr_i  (haddr_i),
    .htrans_i (htrans_i),
    .hwrite_i (hwrite_i),
    .hsize_i  (hsize_i),
    .hwdata_i (hwdata_i),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),
    .hresp_o  (hresp_o)
  );

  initial begin
    clk_ahb = 1'b0;
    forever #(CLK_PERIOD / 2) clk_ahb = ~clk_ahb;
  end

  //////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////
  task automatic stop_failed(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      stop_failed($sformatf("error: %s is %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_failed($sformatf("error: %s is %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_failed($sformatf("error: %s is %0h, expected %0h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic in_region(addr_t addr);
    return (addr[HADDR_W-1:MEM_AW] == SDRAM_BASE[HADDR_W-1:MEM_AW]) ||
           (addr[HADDR_W-1:MEM_AW] == EXT_BASE[HADDR_W-1:MEM_AW]);
  endfunction

  // Model index of byte 0 of the addressed word
  function automatic int model_word(addr_t addr);
    int idx;
    idx = int'(addr[MEM_AW-1:2]) * 4;
    if (addr[HADDR_W-1:MEM_AW] == SDRAM_BASE[HADDR_W-1:MEM_AW]) begin
      idx += MEM_BYTES;
    end
    return idx;
  endfunction

  function automatic data_t model_read(addr_t addr);
    data_t d;
    for (int i = 0; i < 4; i++) begin
      d[8*i +: 8] = model_mem[model_word(addr) + i];
    end
    return d;
  endfunction

  // Little endian, lanes picked by size and low address bits
  task automatic model_write(input addr_t addr, input hsize_t size, input data_t wdata);
    int nbytes;
    int lane0;
    nbytes = 1 << size;
    lane0  = int'(addr[1:0]);
    lane0  = lane0 - (lane0 % nbytes);
    for (int i = lane0; i < lane0 + nbytes; i++) begin
      model_mem[model_word(addr) + i] = wdata[8*i +: 8];
    end
  endtask

  function automatic addr_t rand_addr(addr_t base);
    return base | (addr_t'($urandom) & addr_t'(MEM_BYTES - 4));
  endfunction

  //////////////////////////////////////////////////
  // AHB driver
  //////////////////////////////////////////////////

  // Entered and left 2 ns after a rising edge
  task automatic ahb_xfer(input addr_t addr, input logic write, input hsize_t size,
                          input data_t wdata, output data_t rdata);
    int   waits;
    logic mapped;
    mapped   = in_region(addr);
    haddr_i  = addr;
    htrans_i = HTRANS_NONSEQ;
    hwrite_i = write;
    hsize_i  = size;
    waits    = 0;
    // Address phase waits for a free bus
    @(negedge clk_ahb);
    while (!hready_o) begin
      waits++;
      if (waits > READY_LIMIT) begin
        stop_failed("Bus never became ready for the address phase");
      end
      @(negedge clk_ahb);
    end
    @(posedge clk_ahb);
    #DRV_DLY;
    htrans_i = HTRANS_IDLE;
    hwdata_i = wdata;
    // Data phase, count stall cycles
    waits = 0;
    @(negedge clk_ahb);
    while (!hready_o) begin
      check_resp("hresp_o", hresp_o, !mapped);
      waits++;
      if (waits > READY_LIMIT) begin
        stop_failed("hready_o stuck low in the data phase");
      end
      @(negedge clk_ahb);
    end
    check_resp("hresp_o", hresp_o, !mapped);
    check_cycles("hready_o low cycles", waits, mapped ? MEM_LATENCY : 1);
    rdata = hrdata_o;
    @(posedge clk_ahb);
    #DRV_DLY;
  endtask

  task automatic ahb_write(input addr_t addr, input hsize_t size, input data_t wdata);
    data_t ignored;
    ahb_xfer(addr, 1'b1, size, wdata, ignored);
    if (in_region(addr)) begin
      model_write(addr, size, wdata);
    end
  endtask

  task automatic ahb_read(input addr_t addr, output data_t rdata);
    ahb_xfer(addr, 1'b0, HSIZE_WORD, '0, rdata);
  endtask

  // Stall cycles until hready_o is seen high at a falling edge
  task automatic count_stalls(output int waits);
    waits = 0;
    @(negedge clk_ahb);
    while (!hready_o) begin
      waits++;
      if (waits > READY_LIMIT) begin
        stop_failed("hready_o stuck low in the data phase");
      end
      @(negedge clk_ahb);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic test_word_rw();
    addr_t addrs[$];
    data_t rdata;
    for (int r = 0; r < 2; r++) begin
      addrs.delete();
      for (int i = 0; i < N_WORDS; i++) begin
        addrs.push_back(rand_addr(r == 0 ? SDRAM_BASE : EXT_BASE));
        ahb_write(addrs[i], HSIZE_WORD, $urandom);
      end
      foreach (addrs[i]) begin
        ahb_read(addrs[i], rdata);
        check_data("hrdata_o", rdata, model_read(addrs[i]));
      end
    end
  endtask

  // Full word first so every lane is known before merging
  task automatic test_byte_lanes();
    addr_t addr;
    data_t rdata;
    for (int i = 0; i < N_LANES; i++) begin
      addr = rand_addr(($urandom & 1) ? SDRAM_BASE : EXT_BASE);
      ahb_write(addr, HSIZE_WORD, $urandom);
      ahb_write(addr | addr_t'($urandom & 3), HSIZE_BYTE, $urandom);
      ahb_write(addr | addr_t'($urandom & 2), HSIZE_HALF, $urandom);
      ahb_read(addr, rdata);
      check_data("hrdata_o", rdata, model_read(addr));
    end
  endtask

  // Read address phase held on the bus through the write data phase
  task automatic test_back_to_back();
    addr_t addr;
    data_t wdata;
    int    waits;
    addr     = rand_addr(EXT_BASE);
    wdata    = $urandom;
    haddr_i  = addr;
    htrans_i = HTRANS_NONSEQ;
    hwrite_i = 1'b1;
    hsize_i  = HSIZE_WORD;
    // Bus is idle, so the write is taken on this edge
    @(posedge clk_ahb);
    #DRV_DLY;
    hwrite_i = 1'b0;
    hwdata_i = wdata;
    count_stalls(waits);
    check_resp("hresp_o", hresp_o, 1'b0);
    check_cycles("hready_o low cycles", waits, MEM_LATENCY);
    // Write completes and the read is taken on the same edge
    @(posedge clk_ahb);
    #DRV_DLY;
    htrans_i = HTRANS_IDLE;
    model_write(addr, HSIZE_WORD, wdata);
    count_stalls(waits);
    check_resp("hresp_o", hresp_o, 1'b0);
    check_cycles("hready_o low cycles", waits, MEM_LATENCY);
    check_data("hrdata_o", hrdata_o, model_read(addr));
    @(posedge clk_ahb);
    #DRV_DLY;
  endtask

  // Same low bits as the mapped words, so aliasing would show
  task automatic test_unmapped();
    addr_t bad [3];
    data_t rdata;
    bad = '{32'h4000_0010, 32'h8000_1010, 32'h0000_1010};
    ahb_write(SDRAM_BASE | 32'h10, HSIZE_WORD, $urandom);
    ahb_write(EXT_BASE | 32'h10, HSIZE_WORD, $urandom);
    foreach (bad[i]) begin
      ahb_write(bad[i], HSIZE_WORD, $urandom);
      ahb_read(bad[i], rdata);
    end
    ahb_read(SDRAM_BASE | 32'h10, rdata);
    check_data("hrdata_o", rdata, model_read(SDRAM_BASE | 32'h10));
    ahb_read(EXT_BASE | 32'h10, rdata);
    check_data("hrdata_o", rdata, model_read(EXT_BASE | 32'h10));
  endtask

  task automatic test_soft_reset();
    addr_t addr;
    data_t rdata;
    addr = rand_addr(SDRAM_BASE);
    ahb_write(addr, HSIZE_WORD, $urandom);
    // Reset pulse with a conflicting write held on the bus
    rst_req_i = 1'b1;
    haddr_i   = addr;
    htrans_i  = HTRANS_NONSEQ;
    hwrite_i  = 1'b1;
    hsize_i   = HSIZE_WORD;
    hwdata_i  = ~model_read(addr);
    @(posedge clk_ahb);
    #DRV_DLY;
    rst_req_i = 1'b0;
    repeat (RST_HOLD + 1) begin
      @(negedge clk_ahb);
      check_resp("hready_o", hready_o, 1'b1);
      check_resp("hresp_o", hresp_o, 1'b0);
      @(posedge clk_ahb);
    end
    #DRV_DLY;
    htrans_i = HTRANS_IDLE;
    ahb_read(addr, rdata);
    check_data("hrdata_o", rdata, model_read(addr));
  endtask

  //////////////////////////////////////////////////
  // Main sequence, watchdog, assertion monitor
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    sysrst_n  = 1'b0;
    rst_req_i = 1'b0;
    haddr_i   = '0;
    htrans_i  = HTRANS_IDLE;
    hwrite_i  = 1'b0;
    hsize_i   = HSIZE_WORD;
    hwdata_i  = '0;
    repeat (RESET_CYCLES) @(posedge clk_ahb);
    #DRV_DLY;
    sysrst_n = 1'b1;
    // Let the hold counter and sync stage release
    repeat (RST_HOLD + 2) @(posedge clk_ahb);
    #DRV_DLY;
    test_word_rw();
    test_byte_lanes();
    test_back_to_back();
    test_unmapped();
    test_soft_reset();
    repeat (2) @(posedge clk_ahb);
    if (dut_i.decoder_i.checker_i.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_failed("A bound protocol assertion failed");
    end
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    stop_failed("Watchdog expired before the tests finished");
  end

  initial begin
    wait (dut_i.decoder_i.checker_i.fail_cnt != 0);
    stop_failed("A bound protocol assertion failed");
  end

endmodule

// File: hdl/ahb_decoder.sv
/*
  AHB-Lite address decoder and response mux.
  Selects the SDRAM or external region in the address phase, tracks the
  region of the data phase and returns its ready and read data. Unmapped
  addresses get the two-cycle ERROR response from a built-in slave.
*/
module ahb_decoder
  import ahb_mem_pkg::*;
(
  input  logic    clk_ahb,
  input  logic    rst_ahb_n_i,
  input  addr_t   haddr_i,
  input  htrans_t htrans_i,
  output logic    sel_sdram_o,
  output logic    sel_ext_o,
  input  logic    sdram_hreadyout_i,
  input  data_t   sdram_hrdata_i,
  input  logic    ext_hreadyout_i,
  input  data_t   ext_hrdata_i,
  output logic    hready_o,
  output logic    hresp_o,
  output data_t   hrdata_o
);

  region_t addr_region;
  region_t dp_region_q;
  logic    addr_xfer;
  logic    err_first_q;
  logic    err_second_q;

  //////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////

  // Region match on bits above the 4 KB window
  always_comb begin
    if (haddr_i[HADDR_W-1:MEM_AW] == SDRAM_BASE[HADDR_W-1:MEM_AW]) begin
      addr_region = REGION_SDRAM;
    end else if (haddr_i[HADDR_W-1:MEM_AW] == EXT_BASE[HADDR_W-1:MEM_AW]) begin
      addr_region = REGION_EXT;
    end else begin
      addr_region = REGION_NONE;
    end
  end

  assign addr_xfer   = htrans_xfer(htrans_i);
  assign sel_sdram_o = (addr_region == REGION_SDRAM);
  assign sel_ext_o   = (addr_region == REGION_EXT);

  //////////////////////////////////////////////////
  // Data phase tracking
  //////////////////////////////////////////////////
  always_ff @(posedge clk_ahb or negedge rst_ahb_n_i) begin
    if (!rst_ahb_n_i) begin
      dp_region_q  <= REGION_NONE;
      err_first_q  <= 1'b0;
      err_second_q <= 1'b0;
    end else begin
      // Second ERROR cycle always follows the first
      err_second_q <= err_first_q;
      if (hready_o) begin
        // Idle data phase parks on REGION_NONE with no error
        dp_region_q <= addr_xfer ? addr_region : REGION_NONE;
        err_first_q <= addr_xfer && (addr_region == REGION_NONE);
      end else begin
        err_first_q <= 1'b0;
      end
    end
  end

  // Response mux by data-phase region
  always_comb begin
    case (dp_region_q)
      REGION_SDRAM: begin
        hready_o = sdram_hreadyout_i;
        hrdata_o = sdram_hrdata_i;
      end
      REGION_EXT: begin
        hready_o = ext_hreadyout_i;
        hrdata_o = ext_hrdata_i;
      end
      default: begin
        // Default slave, low only on first ERROR cycle
        hready_o = ~err_first_q;
        hrdata_o = '0;
      end
    endcase
  end

  assign hresp_o = err_first_q | err_second_q;

endmodule

// File: hdl/ahb_mem_pkg.sv
/*
  Shared definitions for the AHB-Lite memory subsystem.
  Holds bus widths, transfer and size codes, the address map and the
  timing constants. RTL modules pull it in by a wildcard import.
*/
package ahb_mem_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////
  localparam int HDATA_W = 32;
  localparam int HADDR_W = 32;
  localparam int HBYTES  = HDATA_W / 8;

  typedef logic [HDATA_W-1:0] data_t;
  typedef logic [HADDR_W-1:0] addr_t;
  typedef logic [HBYTES-1:0]  strb_t;

  // Transfer type codes
  typedef logic [1:0] htrans_t;
  localparam htrans_t HTRANS_IDLE   = 2'd0;
  localparam htrans_t HTRANS_BUSY   = 2'd1;
  localparam htrans_t HTRANS_NONSEQ = 2'd2;
  localparam htrans_t HTRANS_SEQ    = 2'd3;

  // Transfer size codes
  typedef logic [2:0] hsize_t;
  localparam hsize_t HSIZE_BYTE = 3'd0;
  localparam hsize_t HSIZE_HALF = 3'd1;
  localparam hsize_t HSIZE_WORD = 3'd2;

  //////////////////////////////////////////////////
  // Address map and timing
  //////////////////////////////////////////////////
  localparam addr_t SDRAM_BASE  = 32'h8000_0000;
  localparam addr_t EXT_BASE    = 32'h0000_0000;
  localparam int    MEM_AW      = 12;
  localparam int    MEM_WORDS   = 2 ** (MEM_AW - 2);
  localparam int    MEM_LATENCY = 3;
  localparam int    RST_HOLD    = 4;

  // Hold counter, wide enough for any RST_HOLD
  typedef logic [$clog2(RST_HOLD + 1)-1:0] rst_cnt_t;

  typedef enum logic [1:0] {REGION_NONE, REGION_SDRAM, REGION_EXT} region_t;
  typedef enum logic [1:0] {MEM_IDLE, MEM_WAIT, MEM_DONE} mem_state_t;

  // NONSEQ and SEQ are real transfers, IDLE and BUSY are not
  function automatic logic htrans_xfer(htrans_t t);
    case (t)
      HTRANS_NONSEQ, HTRANS_SEQ: return 1'b1;
      HTRANS_IDLE, HTRANS_BUSY:  return 1'b0;
      default:                   return 1'b0;
    endcase
  endfunction

endpackage

// File: hdl/ahb_mem_slave.sv
/*
  Wait-state AHB-Lite memory model.
  Accepts a transfer, holds hreadyout low for LATENCY cycles and then
  completes it in one ready cycle. Writes touch only the selected byte
  lanes, reads return the whole word. Used once per memory region.
*/
module ahb_mem_slave
  import ahb_mem_pkg::*;
#(
  parameter int LATENCY = MEM_LATENCY
) (
  input  logic              clk_ahb,
  input  logic              rst_ahb_n_i,
  input  logic              hsel_i,
  input  logic              hready_i,
  input  logic [MEM_AW-1:0] haddr_i,
  input  htrans_t           htrans_i,
  input  logic              hwrite_i,
  input  hsize_t            hsize_i,
  input  data_t             hwdata_i,
  output data_t             hrdata_o,
  output logic              hreadyout_o
);

  // Wait counter sized for LATENCY, word index for the array
  typedef logic [$clog2(LATENCY + 1)-1:0] lat_cnt_t;
  typedef logic [$clog2(MEM_WORDS)-1:0]   word_t;

  data_t      mem [MEM_WORDS];
  mem_state_t state_q;
  lat_cnt_t   cnt_q;
  logic       accept;
  logic       last_wait;
  strb_t      be;
  word_t      word_q;
  strb_t      be_q;
  logic       write_q;
  data_t      rdata_q;

  // Address phase taken when selected and bus ready
  assign accept    = hsel_i && hready_i && htrans_xfer(htrans_i);
  assign last_wait = (state_q == MEM_WAIT) && (cnt_q == lat_cnt_t'(LATENCY - 1));

  // Byte lanes, little endian
  always_comb begin
    case (hsize_i)
      HSIZE_BYTE: be = strb_t'(1) << haddr_i[1:0];
      HSIZE_HALF: be = strb_t'(3) << {haddr_i[1], 1'b0};
      HSIZE_WORD: be = '1;
      default:    be = '1;
    endcase
  end

  //////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk_ahb or negedge rst_ahb_n_i) begin
    if (!rst_ahb_n_i) begin
      state_q <= MEM_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (accept) begin
            state_q <= MEM_WAIT;
            cnt_q   <= '0;
          end
        end
        MEM_WAIT: begin
          // LATENCY cycles here, one per count
          if (last_wait) begin
            state_q <= MEM_DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        MEM_DONE: begin
          // Back-to-back transfer overlaps this data phase
          if (accept) begin
            state_q <= MEM_WAIT;
            cnt_q   <= '0;
          end else begin
            state_q <= MEM_IDLE;
          end
        end
        default: begin
          state_q <= MEM_IDLE;
        end
      endcase
    end
  end

  // Address phase capture
  always_ff @(posedge clk_ahb) begin
    if (accept) begin
      word_q  <= haddr_i[MEM_AW-1:2];
      be_q    <= be;
      write_q <= hwrite_i;
    end
  end

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk_ahb) begin
    // Write data sampled in the ready cycle
    if ((state_q == MEM_DONE) && hready_i && write_q) begin
      for (int i = 0; i < HBYTES; i++) begin
        if (be_q[i]) begin
          mem[word_q][i*8 +: 8] <= hwdata_i[i*8 +: 8];
        end
      end
    end
    // Read word fetched on the last wait cycle
    if (last_wait && !write_q) begin
      rdata_q <= mem[word_q];
    end
  end

  assign hrdata_o    = rdata_q;
  assign hreadyout_o = (state_q != MEM_WAIT);

endmodule

// File: hdl/ahb_mem_top.sv
/*
  Top level of the AHB-Lite memory subsystem.
  One slave port for an AHB-Lite master. Connects reset conditioning, the
  address decoder and one memory per region (SDRAM and external flash).
*/
module ahb_mem_top
  import ahb_mem_pkg::*;
(
  input  logic    clk_ahb,
  input  logic    sysrst_n,
  input  logic    rst_req_i,
  input  addr_t   haddr_i,
  input  htrans_t htrans_i,
  input  logic    hwrite_i,
  input  hsize_t  hsize_i,
  input  data_t   hwdata_i,
  output data_t   hrdata_o,
  output logic    hready_o,
  output logic    hresp_o
);

  logic  rst_ahb_n;
  logic  sel_sdram;
  logic  sel_ext;
  logic  sdram_hreadyout;
  data_t sdram_hrdata;
  logic  ext_hreadyout;
  data_t ext_hrdata;

  //////////////////////////////////////////////////
  // Reset and decode
  //////////////////////////////////////////////////
  ahb_rst_ctrl rst_ctrl_i (
    .clk_ahb    (clk_ahb),
    .sysrst_n   (sysrst_n),
    .rst_req_i  (rst_req_i),
    .rst_ahb_n_o(rst_ahb_n)
  );

  ahb_decoder decoder_i (
    .clk_ahb          (clk_ahb),
    .rst_ahb_n_i      (rst_ahb_n),
    .haddr_i          (haddr_i),
    .htrans_i         (htrans_i),
    .sel_sdram_o      (sel_sdram),
    .sel_ext_o        (sel_ext),
    .sdram_hreadyout_i(sdram_hreadyout),
    .sdram_hrdata_i   (sdram_hrdata),
    .ext_hreadyout_i  (ext_hreadyout),
    .ext_hrdata_i     (ext_hrdata),
    .hready_o         (hready_o),
    .hresp_o          (hresp_o),
    .hrdata_o         (hrdata_o)
  );

  //////////////////////////////////////////////////
  // Memory regions
  //////////////////////////////////////////////////

  // SDRAM emulated as SRAM at 8000_0000h
  ahb_mem_slave #(
    .LATENCY(MEM_LATENCY)
  ) sdram_mem (
    .clk_ahb    (clk_ahb),
    .rst_ahb_n_i(rst_ahb_n),
    .hsel_i     (sel_sdram),
    .hready_i   (hready_o),
    .haddr_i    (haddr_i[MEM_AW-1:0]),
    .htrans_i   (htrans_i),
    .hwrite_i   (hwrite_i),
    .hsize_i    (hsize_i),
    .hwdata_i   (hwdata_i),
    .hrdata_o   (sdram_hrdata),
    .hreadyout_o(sdram_hreadyout)
  );

  // External flash region at 0000_0000h
  ahb_mem_slave #(
    .LATENCY(MEM_LATENCY)
  ) ext_mem (
    .clk_ahb    (clk_ahb),
    .rst_ahb_n_i(rst_ahb_n),
    .hsel_i     (sel_ext),
    .hready_i   (hready_o),
    .haddr_i    (haddr_i[MEM_AW-1:0]),
    .htrans_i   (htrans_i),
    .hwrite_i   (hwrite_i),
    .hsize_i    (hsize_i),
    .hwdata_i   (hwdata_i),
    .hrdata_o   (ext_hrdata),
    .hreadyout_o(ext_hreadyout)
  );

endmodule

// File: hdl/ahb_rst_ctrl.sv
/*
  AHB reset conditioning.
  Board reset and the system reset request assert the AHB reset at once.
  Release comes RST_HOLD+1 clock edges after both sources are clear.
*/
module ahb_rst_ctrl
  import ahb_mem_pkg::*;
(
  input  logic clk_ahb,
  input  logic sysrst_n,
  input  logic rst_req_i,
  output logic rst_ahb_n_o
);

  logic       rst_src_n;
  rst_cnt_t   hold_cnt_q;
  logic       hold_done;
  logic [1:0] sync_q;

  // Either source pulls reset low asynchronously
  assign rst_src_n = sysrst_n & ~rst_req_i;

  // Hold expires RST_HOLD-1 edges after release
  assign hold_done = (hold_cnt_q == rst_cnt_t'(RST_HOLD - 1));

  always_ff @(posedge clk_ahb or negedge rst_src_n) begin
    if (!rst_src_n) begin
      hold_cnt_q <= '0;
      sync_q     <= '0;
    end else begin
      // Saturating hold counter
      if (!hold_done) begin
        hold_cnt_q <= hold_cnt_q + 1'b1;
      end
      // Two-flop stage for a clean synchronous release
      sync_q <= {sync_q[0], hold_done};
    end
  end

  assign rst_ahb_n_o = sync_q[1];

endmodule
